//--- layer_macros.svh
`ifndef LAYER_MACROS_SVH
`define LAYER_MACROS_SVH

`define NODE_INPUTS 10
`define LAYER_NODES 3
`define NODE_LATENCY 5

`endif

//--- floatPkg.sv
package floatPkg;

	localparam int EXP_WIDTH = 8;
	localparam int MANT_WIDTH = 23;
	localparam int EXP_BIAS = 127;

	// ieee single precision, sign at msb
	typedef struct packed
	{
		logic sign;
		logic [EXP_WIDTH-1:0] exponent;
		logic [MANT_WIDTH-1:0] mantissa;
	} float32T;

	localparam float32T POS_ZERO = 32'h0000_0000;
	localparam float32T MAX_FINITE = 32'h7F7F_FFFF; // overflow saturates here

endpackage

//--- layerPkg.sv
`include "layer_macros.svh"

package layerPkg;

	typedef floatPkg::float32T activationT [`NODE_INPUTS];

	// weights are multiples of 0.25 below 2 in magnitude
	// inputs 0 and 1 carry opposite weights so a matched pair cancels
	localparam floatPkg::float32T WEIGHTS [`LAYER_NODES][`NODE_INPUTS] = '{
		// 0.5 -0.5 1.25 -0.75 0.25 | 1.5 -1.0 0.75 -1.75 1.0
		'{
			32'h3F00_0000, 32'hBF00_0000, 32'h3FA0_0000, 32'hBF40_0000, 32'h3E80_0000,
			32'h3FC0_0000, 32'hBF80_0000, 32'h3F40_0000, 32'hBFE0_0000, 32'h3F80_0000
		},
		// -1.25 1.25 0.75 0.5 -0.25 | -1.5 1.75 -0.5 1.0 -0.75
		'{
			32'hBFA0_0000, 32'h3FA0_0000, 32'h3F40_0000, 32'h3F00_0000, 32'hBE80_0000,
			32'hBFC0_0000, 32'h3FE0_0000, 32'hBF00_0000, 32'h3F80_0000, 32'hBF40_0000
		},
		// 1.0 -1.0 -0.25 1.5 0.75 | -1.25 0.5 1.25 -0.75 0.25
		'{
			32'h3F80_0000, 32'hBF80_0000, 32'hBE80_0000, 32'h3FC0_0000, 32'h3F40_0000,
			32'hBFA0_0000, 32'h3F00_0000, 32'h3FA0_0000, 32'hBF40_0000, 32'h3E80_0000
		}
	};

	// 0.25, -0.5, 1.75
	localparam floatPkg::float32T BIASES [`LAYER_NODES] = '{
		32'h3E80_0000,
		32'hBF00_0000,
		32'h3FE0_0000
	};

endpackage

//--- floatMultiply.sv
`timescale 1ns/1ps

module floatMultiply
(
	input  floatPkg::float32T a,
	input  floatPkg::float32T b,
	output floatPkg::float32T product
);

	localparam int SIG_W = floatPkg::MANT_WIDTH + 1; // hidden bit included
	localparam int PROD_W = 2 * SIG_W;

	logic [PROD_W-1:0] sigProduct;
	logic signed [9:0] expSum; // may dip below zero before the underflow check
	logic resSign;
	logic carry;

	always_comb
	begin
		resSign = a.sign ^ b.sign;
		sigProduct = PROD_W'({1'b1, a.mantissa}) * PROD_W'({1'b1, b.mantissa});
		carry = sigProduct[PROD_W-1]; // product of two 1.x values lies in [1,4)
		expSum = 10'(a.exponent) + 10'(b.exponent) - 10'(floatPkg::EXP_BIAS) + 10'(carry);

		if (a.exponent == '0 || b.exponent == '0)
		begin
			product = floatPkg::POS_ZERO; // zero or subnormal operand
		end
		else if (expSum <= 0)
		begin
			product = floatPkg::POS_ZERO; // flush underflow
		end
		else if (expSum >= 255)
		begin
			product = {resSign, floatPkg::MAX_FINITE.exponent, floatPkg::MAX_FINITE.mantissa};
		end
		else if (carry)
		begin
			product = {resSign, expSum[7:0], sigProduct[PROD_W-2 -: floatPkg::MANT_WIDTH]};
		end
		else
		begin
			// truncation gives round toward zero
			product = {resSign, expSum[7:0], sigProduct[PROD_W-3 -: floatPkg::MANT_WIDTH]};
		end
	end

endmodule

//--- floatAdd.sv
`timescale 1ns/1ps

module floatAdd
(
	input  floatPkg::float32T a,
	input  floatPkg::float32T b,
	output floatPkg::float32T sum
);

	localparam int GUARD = 3;
	localparam int ALIGN_W = floatPkg::MANT_WIDTH + 1 + GUARD; // hidden, mantissa, guard
	localparam int MW = floatPkg::MANT_WIDTH;

	floatPkg::float32T opBig;
	floatPkg::float32T opSmall;
	logic [7:0] expDiff;
	logic [ALIGN_W-1:0] sigBig;
	logic [ALIGN_W-1:0] sigSmall;
	logic [ALIGN_W:0] rawSum; // top bit catches the carry
	logic [4:0] lz;
	logic [ALIGN_W-1:0] normSig;
	logic subtract;

	function automatic logic [4:0] leadingZeros(input logic [ALIGN_W-1:0] v);
		logic [4:0] count;
		count = 5'd0;
		// highest set bit wins
		for (int i = 0; i < ALIGN_W; i++)
		begin
			if (v[i])
				count = 5'(ALIGN_W - 1 - i);
		end
		return count;
	endfunction

	always_comb
	begin
		// order by magnitude, sign ignored
		if (a[30:0] >= b[30:0])
		begin
			opBig = a;
			opSmall = b;
		end
		else
		begin
			opBig = b;
			opSmall = a;
		end

		expDiff = opBig.exponent - opSmall.exponent;
		sigBig = {1'b1, opBig.mantissa, {GUARD{1'b0}}};
		if (expDiff >= 8'(ALIGN_W))
			sigSmall = '0; // shifted out completely
		else
			sigSmall = {1'b1, opSmall.mantissa, {GUARD{1'b0}}} >> expDiff;

		subtract = opBig.sign ^ opSmall.sign;
		if (subtract)
			rawSum = {1'b0, sigBig} - {1'b0, sigSmall};
		else
			rawSum = {1'b0, sigBig} + {1'b0, sigSmall};

		lz = leadingZeros(rawSum[ALIGN_W-1:0]);
		normSig = rawSum[ALIGN_W-1:0] << lz;

		if (a.exponent == '0 && b.exponent == '0)
		begin
			sum = floatPkg::POS_ZERO;
		end
		else if (a.exponent == '0)
		begin
			sum = b;
		end
		else if (b.exponent == '0)
		begin
			sum = a;
		end
		else if (rawSum == '0)
		begin
			sum = floatPkg::POS_ZERO; // exact cancellation
		end
		else if (rawSum[ALIGN_W])
		begin
			// carry out, one right shift
			if (opBig.exponent == 8'd254)
				sum = {opBig.sign, floatPkg::MAX_FINITE.exponent, floatPkg::MAX_FINITE.mantissa};
			else
				sum = {opBig.sign, 8'(opBig.exponent + 8'd1), rawSum[ALIGN_W-1 -: MW]};
		end
		else if (opBig.exponent <= 8'(lz))
		begin
			sum = floatPkg::POS_ZERO; // result would be subnormal
		end
		else
		begin
			sum = {opBig.sign, 8'(opBig.exponent - 8'(lz)), normSig[ALIGN_W-2 -: MW]};
		end
	end

endmodule

//--- neuronNode.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module neuronNode
#(
	parameter int nodeIndex = 0
)
(
	input  logic clk,
	input  layerPkg::activationT activation,
	output floatPkg::float32T result
);

	floatPkg::float32T productWire [`NODE_INPUTS];
	floatPkg::float32T productReg [`NODE_INPUTS];
	floatPkg::float32T pairWire [5];
	floatPkg::float32T pairReg [5];
	floatPkg::float32T groupWire [3];
	floatPkg::float32T groupReg [3];
	floatPkg::float32T upperWire;
	floatPkg::float32T upperReg;
	floatPkg::float32T biasedReg;
	floatPkg::float32T finalWire;

	if (nodeIndex >= `LAYER_NODES)
	begin : badIndex
		$error("neuronNode: nodeIndex %0d has no weight row", nodeIndex);
	end

	// stage 1: products
	for (genvar i = 0; i < `NODE_INPUTS; i++)
	begin : mulGen
		floatMultiply mult
		(
			.a(activation[i]),
			.b(layerPkg::WEIGHTS[nodeIndex][i]),
			.product(productWire[i])
		);
	end

	// stage 2: neighbouring products pairwise
	for (genvar p = 0; p < 5; p++)
	begin : pairGen
		floatAdd addPair
		(
			.a(productReg[2*p]),
			.b(productReg[2*p+1]),
			.sum(pairWire[p])
		);
	end

	// stage 3: two pair-of-pairs plus the bias sum
	for (genvar g = 0; g < 2; g++)
	begin : groupGen
		floatAdd addGroup
		(
			.a(pairReg[2*g]),
			.b(pairReg[2*g+1]),
			.sum(groupWire[g])
		);
	end

	floatAdd addBias
	(
		.a(pairReg[4]),
		.b(layerPkg::BIASES[nodeIndex]),
		.sum(groupWire[2])
	);

	// stage 4
	floatAdd addUpper
	(
		.a(groupReg[0]),
		.b(groupReg[1]),
		.sum(upperWire)
	);

	// stage 5
	floatAdd addFinal
	(
		.a(upperReg),
		.b(biasedReg),
		.sum(finalWire)
	);

	always_ff @(posedge clk)
	begin
		productReg <= productWire;
		pairReg <= pairWire;
		groupReg <= groupWire;
		upperReg <= upperWire;
		biasedReg <= groupReg[2]; // waits a stage for the upper sum
		result <= finalWire.sign ? floatPkg::POS_ZERO : finalWire; // relu
	end

endmodule

//--- denseLayer.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module denseLayer
(
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  layerPkg::activationT activation,
	output logic outValid,
	output floatPkg::float32T nodeOut [`LAYER_NODES]
);

	logic [`NODE_LATENCY-1:0] validPipe; // one bit per neuron stage

	for (genvar n = 0; n < `LAYER_NODES; n++)
	begin : nodeGen
		neuronNode
		#(
			.nodeIndex(n)
		)
		node
		(
			.clk(clk),
			.activation(activation),
			.result(nodeOut[n])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[`NODE_LATENCY-2:0], inValid};
	end

	assign outValid = validPipe[`NODE_LATENCY-1];

endmodule

//--- denseLayer_properties.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module denseLayer_properties
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input layerPkg::activationT activation,
	input logic outValid,
	input floatPkg::float32T nodeOut [`LAYER_NODES]
);

	int errorCount = 0;
	layerPkg::activationT actHist [`NODE_LATENCY]; // [0] is the newest
	logic [`NODE_LATENCY-1:0] validHist;
	real expected [`LAYER_NODES];

	// normal numbers only, zero exponent reads as zero
	function automatic real toReal(input floatPkg::float32T f);
		real mag;
		if (f.exponent == 8'd0)
			return 0.0;
		mag = 1.0 + real'(f.mantissa) / 8388608.0;
		for (int e = 127; e < int'(f.exponent); e++)
			mag = mag * 2.0;
		for (int e = int'(f.exponent); e < 127; e++)
			mag = mag / 2.0;
		return f.sign ? -mag : mag;
	endfunction

	function automatic real neuronModel(input int node, input layerPkg::activationT act);
		real acc;
		acc = toReal(layerPkg::BIASES[node]);
		for (int i = 0; i < `NODE_INPUTS; i++)
			acc = acc + toReal(act[i]) * toReal(layerPkg::WEIGHTS[node][i]);
		return (acc > 0.0) ? acc : 0.0; // relu
	endfunction

	always @(posedge clk)
	begin
		if (reset)
			validHist <= '0;
		else
			validHist <= {validHist[`NODE_LATENCY-2:0], inValid};
		actHist[0] <= activation;
		for (int s = 1; s < `NODE_LATENCY; s++)
			actHist[s] <= actHist[s-1];
	end

	always_comb
	begin
		for (int n = 0; n < `LAYER_NODES; n++)
			expected[n] = neuronModel(n, actHist[`NODE_LATENCY-1]);
	end

	resetQuiet: assert property (@(posedge clk) reset |=> !outValid)
		else
		begin
			errorCount++;
			$error("ERROR t=%0t outValid expected 0 got %b after reset", $time, outValid);
		end

	latencyCheck: assert property (@(posedge clk) disable iff (reset)
		outValid == validHist[`NODE_LATENCY-1])
		else
		begin
			errorCount++;
			$error("ERROR t=%0t outValid expected %b got %b", $time,
				validHist[`NODE_LATENCY-1], outValid);
		end

	for (genvar n = 0; n < `LAYER_NODES; n++)
	begin : nodeChecks
		valueCheck: assert property (@(posedge clk) disable iff (reset)
			outValid |-> toReal(nodeOut[n]) == expected[n])
			else
			begin
				errorCount++;
				$error("ERROR t=%0t nodeOut[%0d] expected %f got %f (%h)", $time, n,
					expected[n], toReal(nodeOut[n]), nodeOut[n]);
			end

		signCheck: assert property (@(posedge clk) disable iff (reset)
			outValid |-> !nodeOut[n].sign)
			else
			begin
				errorCount++;
				$error("ERROR t=%0t nodeOut[%0d] sign expected 0 got 1 (%h)", $time, n,
					nodeOut[n]);
			end

		// rectified or cancelled results must be +0 exactly
		zeroCheck: assert property (@(posedge clk) disable iff (reset)
			outValid && expected[n] == 0.0 |-> nodeOut[n] == floatPkg::POS_ZERO)
			else
			begin
				errorCount++;
				$error("ERROR t=%0t nodeOut[%0d] expected %h got %h", $time, n,
					floatPkg::POS_ZERO, nodeOut[n]);
			end
	end

endmodule

bind denseLayer denseLayer_properties props
(
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.activation(activation),
	.outValid(outValid),
	.nodeOut(nodeOut)
);

//--- tb_denseLayer.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module tb_denseLayer;

	localparam int PERIOD = 20;
	localparam int RANDOM_VECTORS = 200;
	localparam int DIRECTED_VECTORS = 4;
	localparam int MAX_GAP = 3;
	// each vector takes its strobe cycle plus at most MAX_GAP idle cycles
	localparam int TIMEOUT = ((RANDOM_VECTORS + DIRECTED_VECTORS) * (MAX_GAP + 1) + 20) * PERIOD;

	logic clk;
	logic reset;
	logic inValid;
	layerPkg::activationT activation;
	logic outValid;
	floatPkg::float32T nodeOut [`LAYER_NODES];

	logic [15:0] lfsr;
	int sentCount = 0;
	int resultCount = 0;
	int errors;

	denseLayer UUT
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.activation(activation),
		.outValid(outValid),
		.nodeOut(nodeOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (outValid)
			resultCount <= resultCount + 1;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomBits(input int count, output int value);
		value = 0;
		for (int b = 0; b < count; b++)
		begin
			lfsr = lfsrStep(lfsr);
			value = value | (int'(lfsr[0]) << b);
		end
	endtask

	// small integers only, here -8..7
	function automatic floatPkg::float32T intToFloat(input int value);
		int mag;
		int msb;
		floatPkg::float32T f;
		f = floatPkg::POS_ZERO;
		if (value != 0)
		begin
			mag = (value < 0) ? -value : value;
			msb = 0;
			for (int i = 0; i < 8; i++)
			begin
				if (mag >= (1 << i))
					msb = i;
			end
			f.sign = (value < 0);
			f.exponent = 8'(127 + msb);
			f.mantissa = 23'(mag << (23 - msb)); // hidden bit drops off the top
		end
		return f;
	endfunction

	// called on a falling edge, returns on the next one
	task automatic sendVector(input layerPkg::activationT vec);
		activation = vec;
		inValid = 1'b1;
		sentCount++;
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic sendFilled(input int value);
		layerPkg::activationT vec;
		for (int i = 0; i < `NODE_INPUTS; i++)
			vec[i] = intToFloat(value);
		sendVector(vec);
	endtask

	// inputs 0 and 1 have opposite weights in every row
	task automatic sendCancel(input int value);
		layerPkg::activationT vec;
		for (int i = 0; i < `NODE_INPUTS; i++)
			vec[i] = floatPkg::POS_ZERO;
		vec[0] = intToFloat(value);
		vec[1] = intToFloat(value);
		sendVector(vec);
	endtask

	task automatic sendRandom(input int gapBits);
		layerPkg::activationT vec;
		int raw;
		int gap;
		for (int i = 0; i < `NODE_INPUTS; i++)
		begin
			randomBits(4, raw);
			vec[i] = intToFloat((raw >= 8) ? raw - 16 : raw);
		end
		sendVector(vec);
		gap = 0;
		if (gapBits > 0)
			randomBits(gapBits, gap);
		repeat (gap) @(negedge clk);
	endtask

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		for (int i = 0; i < `NODE_INPUTS; i++)
			activation[i] = floatPkg::POS_ZERO;
		lfsr = 16'd46953;

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (3) @(negedge clk); // outValid must stay low here

		sendFilled(0); // bias only
		sendFilled(-8); // all sums negative
		sendCancel(5);
		sendCancel(-7);
		repeat (`NODE_LATENCY + 2) @(negedge clk);

		for (int k = 0; k < RANDOM_VECTORS / 2; k++)
			sendRandom(0); // back to back
		for (int k = 0; k < RANDOM_VECTORS / 2; k++)
			sendRandom(2); // gaps of 0..MAX_GAP

		wait (resultCount >= sentCount);
		repeat (3) @(negedge clk);

		errors = UUT.props.errorCount;
		$display("vectors sent %0d, results %0d, errors %0d", sentCount, resultCount, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(TIMEOUT);
		$display("timeout: %0d of %0d results seen after %0d ns", resultCount, sentCount,
			TIMEOUT);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+.
floatPkg.sv
layerPkg.sv
floatMultiply.sv
floatAdd.sv
neuronNode.sv
denseLayer.sv
denseLayer_properties.sv
tb_denseLayer.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_denseLayer \
	-f compile.f -o simDenseLayer > "$LOG" 2>&1 &&
	./obj_dir/simDenseLayer +verilator+error+limit+1000000 >> "$LOG" 2>&1 ||
	echo "Simulation failed" >> "$LOG"

cat "$LOG"
! grep -q "Simulation failed" "$LOG" && grep -q "Simulation completed successfully" "$LOG"
